//--- zx_mem_macros.svh
//======================================
// Memory paging unit constants
// Address width, port numbers, ROM base
// and fixed bank numbers
//======================================

`ifndef ZX_MEM_MACROS_SVH
`define ZX_MEM_MACROS_SVH

// External memory address width
`define ZX_ADDR_W 25

// Upper nibble of a ROM page address in external memory
`define ZX_ROM_PREFIX 4'b1000

// Profi 1024K extended paging port
`define ZX_PORT_DFFD 16'hDFFD

// Opcode fetch from 3Dxx in the 48K ROM enters TR-DOS
`define ZX_TRDOS_HOOK 6'h3D

// Banks hardwired to 4000-7FFF and 8000-BFFF
`define ZX_BANK_SCREEN 3'd5
`define ZX_BANK_MID 3'd2

`endif

//--- zx_mem_pkg.sv
//======================================
// Shared types of the paging unit
// Machine model, Z80 bus, page state,
// +3 register views, memory request
//======================================

`include "zx_mem_macros.svh"

package zx_mem_pkg;

	// Machine models, same order as the host menu
	typedef enum logic [2:0] {
		MACH_128   = 3'd0,
		MACH_P512  = 3'd1,
		MACH_P1024 = 3'd2,
		MACH_48    = 3'd3,
		MACH_PLUS3 = 3'd4
	} machine_t;

	// Z80 bus as seen by the paging unit, strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  dout;
		logic        mreq;
		logic        iorq;
		logic        rd;
		logic        wr;
		logic        m1;
	} z80_bus_t;

	// 1FFD in normal paging mode
	typedef struct packed {
		logic [4:0] misc;
		logic       rom_hi;
		logic       unused;
		logic       special;
	} p3_norm_t;

	// 1FFD in special (all RAM) mode
	typedef struct packed {
		logic [4:0] misc;
		logic [1:0] cfg;
		logic       special;
	} p3_spec_t;

	// Bit 0 decides which of the two views applies
	typedef union packed {
		p3_norm_t norm;
		p3_spec_t spec;
	} p3_page_u;

	typedef struct packed {
		logic [7:0] page_7ffd;
		p3_page_u   page_1ffd;
		logic [2:0] page_ext;
		logic       zx48;
		logic       plus3;
	} page_state_t;

	// Request towards external memory
	typedef struct packed {
		logic [`ZX_ADDR_W-1:0] addr;
		logic                  we;
	} ram_req_t;

endpackage

//--- zx_page_regs.sv
//======================================
// Paging registers
// Machine model latch, 7FFD, 1FFD and the
// Pentagon / Profi extended bank bits
//======================================

`include "zx_mem_macros.svh"

module zx_page_regs (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  zx_mem_pkg::machine_t    machine,
	input  zx_mem_pkg::z80_bus_t    bus,
	output zx_mem_pkg::page_state_t state
);

	import zx_mem_pkg::*;

	// Extended memory models, held next to the exported flags
	logic p512;
	logic p1024;

	logic io_wr;
	logic io_wr_q;
	logic io_wr_new;

	logic locked;
	logic sel_7ffd;
	logic sel_1ffd;
	logic sel_dffd;

	//======================================
	// Port decode
	//======================================

	// Port write cycle, M1 excluded so interrupt acknowledge is ignored
	assign io_wr     = bus.iorq & bus.wr & ~bus.m1;
	assign io_wr_new = io_wr & ~io_wr_q;

	// 48K has no paging at all, bit 5 locks until reset
	assign locked = state.zx48 | state.page_7ffd[5];

	// Partial decode as on the real boards
	// +3 needs A14 high to keep 7FFD apart from 1FFD and 2FFD
	assign sel_7ffd = ~bus.addr[15] & ~bus.addr[1] &
		(bus.addr[14] | ~state.plus3) & ~locked;

	assign sel_1ffd = state.plus3 & ~locked &
		(bus.addr[15:12] == 4'b0001) & ~bus.addr[1];

	// Profi port is fully decoded and ignores the lock
	assign sel_dffd = p1024 & (bus.addr == `ZX_PORT_DFFD);

	//======================================
	// Registers
	//======================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			state   <= '0;

			// Model is sampled for as long as reset is held
			state.zx48  <= (machine == MACH_48);
			state.plus3 <= (machine == MACH_PLUS3);
			p512        <= (machine == MACH_P512);
			p1024       <= (machine == MACH_P1024);
		end else begin
			io_wr_q <= io_wr;

			if (io_wr_new) begin
				if (sel_7ffd) begin
					state.page_7ffd <= bus.dout;
					// Pentagon 512K keeps bank bits 4:3 in D7:D6
					if (p512) begin
						state.page_ext[1:0] <= bus.dout[7:6];
					end
				end else if (sel_1ffd) begin
					state.page_1ffd <= bus.dout;
				end

				if (sel_dffd) begin
					state.page_ext <= bus.dout[2:0];
				end
			end
		end
	end

	//======================================
	// Checks
	//======================================

	// Upper bank bits exist only on the extended models
	a_ext_only_big: assert property (
		@(posedge clk_sys) disable iff (reset)
		!(p512 || p1024) |-> (state.page_ext == 3'd0)
	) else $error("page_ext set on a model without extended memory");

endmodule

//--- zx_rom_pager.sv
//======================================
// TR-DOS ROM paging
// Entry on fetch from 3Dxx in 48K BASIC,
// exit on any fetch from RAM
//======================================

`include "zx_mem_macros.svh"

module zx_rom_pager (
	input  logic                    clk_sys,
	input  logic                    reset,
	input  zx_mem_pkg::z80_bus_t    bus,
	input  zx_mem_pkg::page_state_t state,
	output logic                    trdos
);

	logic fetch;
	logic fetch_q;
	logic fetch_new;
	logic fetch_ram;
	logic hook_hit;
	logic active_48_rom;

	// Opcode fetch counted once per M1 cycle
	assign fetch     = bus.m1 & bus.mreq;
	assign fetch_new = fetch & ~fetch_q;

	// Anything from 4000 up is RAM
	assign fetch_ram = (bus.addr[15:14] != 2'b00);
	assign hook_hit  = (bus.addr[13:8] == `ZX_TRDOS_HOOK);

	// 48K BASIC ROM currently paged in
	// On +3 it is ROM 3, which needs both ROM bits and normal mode
	assign active_48_rom = state.zx48 |
		(state.page_7ffd[4] & ~state.plus3) |
		(state.plus3 & state.page_7ffd[4] & state.page_1ffd.norm.rom_hi &
			~state.page_1ffd.norm.special);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			fetch_q <= 1'b0;
			trdos   <= 1'b0;
		end else begin
			fetch_q <= fetch;

			if (fetch_new) begin
				if (fetch_ram) begin
					trdos <= 1'b0;
				end else if (hook_hit && active_48_rom) begin
					trdos <= 1'b1;
				end
			end
		end
	end

	// TR-DOS is entered only from a new fetch inside 3D00-3DFF
	a_trdos_entry_in_rom: assert property (
		@(posedge clk_sys) disable iff (reset)
		$rose(trdos) |-> $past(fetch_new && (bus.addr[15:8] == {2'b00, `ZX_TRDOS_HOOK}))
	) else $error("trdos entered on a fetch outside 3D00-3DFF");

endmodule

//--- zx_addr_map.sv
//======================================
// CPU to external memory mapping
// ROM page select, normal and +3 special
// layouts, write protection of ROM
//======================================

`include "zx_mem_macros.svh"

module zx_addr_map (
	input  zx_mem_pkg::z80_bus_t    bus,
	input  zx_mem_pkg::page_state_t state,
	input  logic                    trdos,
	output zx_mem_pkg::ram_req_t    mem
);

	logic [1:0] region;
	logic       special;
	logic [1:0] cfg;
	logic [3:0] rom_page;
	logic [5:0] ram_page;
	logic [7:0] page;

	assign region   = bus.addr[15:14];
	assign special  = state.page_1ffd.spec.special;
	assign cfg      = state.page_1ffd.spec.cfg;

	// 512K / 1024K bank bits sit above the 128K bank number
	assign ram_page = {state.page_ext, state.page_7ffd[2:0]};

	//======================================
	// ROM page
	//======================================

	always_comb begin
		if (trdos) begin
			rom_page = 4'b0001;
		end else if (state.plus3) begin
			rom_page = {2'b01, state.page_1ffd.norm.rom_hi, state.page_7ffd[4]};
		end else begin
			// 48K always sits on the BASIC ROM
			rom_page = {3'b001, state.zx48 | state.page_7ffd[4]};
		end
	end

	//======================================
	// Page per 16K region
	//======================================

	always_comb begin
		if (!special) begin
			case (region)
				2'd0:    page = {`ZX_ROM_PREFIX, rom_page};
				2'd1:    page = {5'd0, `ZX_BANK_SCREEN};
				2'd2:    page = {5'd0, `ZX_BANK_MID};
				default: page = {2'd0, ram_page};
			endcase
		end else begin
			// +3 all-RAM layouts 0-1-2-3, 4-5-6-7, 4-5-6-3, 4-7-6-3
			case (region)
				2'd0:    page = {5'd0, |cfg, 2'b00};
				2'd1:    page = {5'd0, |cfg, &cfg, 1'b1};
				2'd2:    page = {5'd0, |cfg, 2'b10};
				default: page = {5'd0, cfg == 2'd1, 2'b11};
			endcase
		end
	end

	//======================================
	// Request
	//======================================

	always_comb begin
		mem.addr = {{(`ZX_ADDR_W - 22){1'b0}}, page, bus.addr[13:0]};

		// ROM below 4000 is read only unless all RAM is mapped
		mem.we = bus.mreq & bus.wr & (special | (region != 2'd0));

		// No write may land anywhere in the ROM area of external memory
		assert (!(mem.we && mem.addr[`ZX_ADDR_W-1:18] == {3'b000, `ZX_ROM_PREFIX}))
		else $error("write enable on ROM address %h", mem.addr);
	end

endmodule

//--- zx_mem_top.sv
//======================================
// Memory paging unit top level
// Paging registers, TR-DOS pager and
// address map
//======================================

module zx_mem_top (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  zx_mem_pkg::machine_t machine,
	input  zx_mem_pkg::z80_bus_t bus,
	output zx_mem_pkg::ram_req_t mem
);

	import zx_mem_pkg::*;

	page_state_t state;
	logic        trdos;

	// Port writes into the paging registers
	zx_page_regs u_page_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.machine (machine),
		.bus     (bus),
		.state   (state)
	);

	// TR-DOS entry and exit from opcode fetches
	zx_rom_pager u_rom_pager (
		.clk_sys (clk_sys),
		.reset   (reset),
		.bus     (bus),
		.state   (state),
		.trdos   (trdos)
	);

	// Same-cycle address translation
	zx_addr_map u_addr_map (
		.bus   (bus),
		.state (state),
		.trdos (trdos),
		.mem   (mem)
	);

endmodule

//--- tb_zx_mem.sv
//======================================
// Testbench of the memory paging unit
// Reference model, comparing process and
// directed scenarios per machine model
//======================================

`include "zx_mem_macros.svh"

module tb_zx_mem;

	import zx_mem_pkg::*;

	// Scenarios take about 600 cycles
	localparam int MAX_CYCLES = 4000;

	logic        clk_sys;
	logic        reset;
	machine_t    machine;
	z80_bus_t    bus;
	ram_req_t    mem;

	integer      seed = 32'hb21f4012;
	logic [31:0] rnd;
	int          errors = 0;
	int          checks = 0;
	int          cycles = 0;

	// Reference copy of the paging state
	logic [7:0]  ref_7ffd;
	logic [7:0]  ref_1ffd;
	logic [2:0]  ref_ext;
	logic        ref_zx48;
	logic        ref_plus3;
	logic        ref_p512;
	logic        ref_p1024;
	logic        ref_trdos;
	logic        prev_io;
	logic        prev_fetch;

	zx_mem_top u_zx_mem_top (
		.clk_sys (clk_sys),
		.reset   (reset),
		.machine (machine),
		.bus     (bus),
		.mem     (mem)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Cycle limit of %0d reached before the scenarios finished", MAX_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	//======================================
	// Reference model
	//======================================

	// Banks for regions 3..0 of each +3 all-RAM layout
	function automatic logic [2:0] all_ram_bank(input logic [1:0] cfg,
			input logic [1:0] region);
		logic [11:0] row;
		case (cfg)
			2'd0:    row = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1:    row = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2:    row = {3'd3, 3'd6, 3'd5, 3'd4};
			default: row = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
		return row[region*3 +: 3];
	endfunction

	function automatic ram_req_t expected_mem(input z80_bus_t b);
		ram_req_t    r;
		logic [1:0]  region;
		logic [3:0]  rom;
		logic [7:0]  page;
		logic        special;
		region  = b.addr[15:14];
		special = ref_1ffd[0];
		if (ref_trdos)
			rom = 4'b0001;
		else if (ref_plus3)
			rom = {2'b01, ref_1ffd[2], ref_7ffd[4]};
		else
			rom = {3'b001, ref_zx48 | ref_7ffd[4]};
		if (special) begin
			page = {5'd0, all_ram_bank(ref_1ffd[2:1], region)};
		end else begin
			case (region)
				2'd0:    page = {4'b1000, rom};
				2'd1:    page = 8'd5;
				2'd2:    page = 8'd2;
				default: page = {2'b00, ref_ext, ref_7ffd[2:0]};
			endcase
		end
		r.addr = {3'b000, page, b.addr[13:0]};
		r.we   = b.mreq & b.wr & (special | (region != 2'd0));
		return r;
	endfunction

	// Register and TR-DOS updates seen at a rising edge
	task automatic update_reference();
		logic       io_new;
		logic       fetch_new;
		logic       locked;
		logic       rom48;
		logic [7:0] n_7ffd;
		logic [7:0] n_1ffd;
		logic [2:0] n_ext;
		if (reset) begin
			ref_7ffd   = '0;
			ref_1ffd   = '0;
			ref_ext    = '0;
			ref_zx48   = (machine == MACH_48);
			ref_plus3  = (machine == MACH_PLUS3);
			ref_p512   = (machine == MACH_P512);
			ref_p1024  = (machine == MACH_P1024);
			ref_trdos  = 1'b0;
			prev_io    = 1'b0;
			prev_fetch = 1'b0;
		end else begin
			io_new    = bus.iorq & bus.wr & ~bus.m1 & ~prev_io;
			fetch_new = bus.m1 & bus.mreq & ~prev_fetch;
			locked    = ref_zx48 | ref_7ffd[5];
			rom48     = ref_zx48 | (ref_7ffd[4] & ~ref_plus3) |
				(ref_plus3 & ref_7ffd[4] & ref_1ffd[2] & ~ref_1ffd[0]);
			n_7ffd = ref_7ffd;
			n_1ffd = ref_1ffd;
			n_ext  = ref_ext;
			if (io_new && !locked) begin
				if (!bus.addr[15] && !bus.addr[1] && (bus.addr[14] || !ref_plus3)) begin
					n_7ffd = bus.dout;
					if (ref_p512)
						n_ext[1:0] = bus.dout[7:6];
				end else if (ref_plus3 && bus.addr[15:12] == 4'h1 && !bus.addr[1]) begin
					n_1ffd = bus.dout;
				end
			end
			if (io_new && ref_p1024 && bus.addr == `ZX_PORT_DFFD)
				n_ext = bus.dout[2:0];
			if (fetch_new) begin
				if (bus.addr >= 16'h4000)
					ref_trdos = 1'b0;
				else if (bus.addr[13:8] == 6'h3D && rom48)
					ref_trdos = 1'b1;
			end
			ref_7ffd   = n_7ffd;
			ref_1ffd   = n_1ffd;
			ref_ext    = n_ext;
			prev_io    = bus.iorq & bus.wr & ~bus.m1;
			prev_fetch = bus.m1 & bus.mreq;
		end
	endtask

	always @(posedge clk_sys) begin
		update_reference();
	end

	// Compare 10 units before each rising edge
	initial begin
		ram_req_t exp;
		forever begin
			@(negedge clk_sys);
			#40;
			if (!reset) begin
				exp = expected_mem(bus);
				check_value("mem.addr", {7'd0, mem.addr}, {7'd0, exp.addr});
				check_value("mem.we", {31'd0, mem.we}, {31'd0, exp.we});
			end
		end
	end

	//======================================
	// Bus stimulus
	//======================================

	task automatic next_drive();
		@(posedge clk_sys);
		#10;
	endtask

	function automatic logic [15:0] rand_addr(input logic [1:0] region);
		logic [31:0] r;
		r = $random(seed);
		return {region, r[13:0]};
	endfunction

	task automatic apply_reset(input machine_t m);
		next_drive();
		reset   = 1'b1;
		machine = m;
		bus     = '0;
		repeat (5) @(posedge clk_sys);
		#10;
		reset = 1'b0;
	endtask

	task automatic drive_mem(input logic [15:0] addr, input logic write, input logic m1);
		rnd      = $random(seed);
		bus      = '0;
		bus.addr = addr;
		bus.dout = rnd[7:0];
		bus.mreq = 1'b1;
		bus.rd   = ~write;
		bus.wr   = write;
		bus.m1   = m1;
	endtask

	task automatic mem_access(input logic [15:0] addr, input logic write);
		next_drive();
		drive_mem(addr, write, 1'b0);
		next_drive();
		bus = '0;
	endtask

	task automatic fetch(input logic [15:0] addr);
		next_drive();
		drive_mem(addr, 1'b0, 1'b1);
		next_drive();
		bus = '0;
	endtask

	// Only the first data value of a held strobe counts
	task automatic io_write(input logic [15:0] addr, input logic [7:0] data, input int hold);
		next_drive();
		bus      = '0;
		bus.addr = addr;
		bus.dout = data;
		bus.iorq = 1'b1;
		bus.wr   = 1'b1;
		repeat (hold - 1) begin
			next_drive();
			rnd      = $random(seed);
			bus.dout = rnd[7:0];
		end
		next_drive();
		bus = '0;
	endtask

	// Direct check of the 16K page number and write enable
	task automatic expect_access(input logic [15:0] addr, input logic write,
			input logic [7:0] page, input logic we);
		next_drive();
		drive_mem(addr, write, 1'b0);
		#80;
		check_value("mem.addr[21:14]", {24'd0, mem.addr[21:14]}, {24'd0, page});
		check_value("mem.we", {31'd0, mem.we}, {31'd0, we});
		next_drive();
		bus = '0;
	endtask

	task automatic random_sweep(input int n);
		repeat (n) begin
			rnd = $random(seed);
			case (rnd[17:16])
				2'd0:    fetch(rnd[15:0]);
				2'd1:    mem_access(rnd[15:0], 1'b1);
				default: mem_access(rnd[15:0], 1'b0);
			endcase
		end
	endtask

	//======================================
	// Scenarios
	//======================================

	initial begin
		reset   = 1'b1;
		machine = MACH_128;
		bus     = '0;

		// 128K straight after reset
		apply_reset(MACH_128);
		for (int r = 0; r < 4; r++) begin
			repeat (3) begin
				mem_access(rand_addr(r[1:0]), 1'b0);
				mem_access(rand_addr(r[1:0]), 1'b1);
			end
		end
		expect_access(rand_addr(2'd0), 1'b1, 8'h82, 1'b0);
		expect_access(rand_addr(2'd1), 1'b1, 8'h05, 1'b1);
		expect_access(rand_addr(2'd2), 1'b1, 8'h02, 1'b1);
		expect_access(rand_addr(2'd3), 1'b1, 8'h00, 1'b1);

		// 7FFD on the 128K model
		apply_reset(MACH_128);
		io_write(16'h7FFD, 8'h03, 1);
		expect_access(rand_addr(2'd3), 1'b0, 8'h03, 1'b0);
		io_write(16'h7FFD, 8'h16, 4);
		expect_access(rand_addr(2'd3), 1'b0, 8'h06, 1'b0);
		expect_access(rand_addr(2'd0), 1'b0, 8'h83, 1'b0);
		io_write(16'hFFFD, 8'h01, 1);
		expect_access(rand_addr(2'd3), 1'b1, 8'h06, 1'b1);
		io_write(16'h0C7D, 8'h04, 1);
		expect_access(rand_addr(2'd3), 1'b0, 8'h04, 1'b0);
		random_sweep(20);
		io_write(16'h7FFD, 8'h25, 1);
		io_write(16'h7FFD, 8'h17, 1);
		expect_access(rand_addr(2'd3), 1'b0, 8'h05, 1'b0);
		expect_access(rand_addr(2'd0), 1'b0, 8'h82, 1'b0);
		random_sweep(20);

		// Extended bank bits
		apply_reset(MACH_P512);
		io_write(16'h7FFD, 8'hC3, 1);
		expect_access(rand_addr(2'd3), 1'b0, 8'h1B, 1'b0);
		io_write(`ZX_PORT_DFFD, 8'h07, 1);
		expect_access(rand_addr(2'd3), 1'b0, 8'h1B, 1'b0);
		random_sweep(10);
		apply_reset(MACH_P1024);
		io_write(`ZX_PORT_DFFD, 8'h05, 1);
		io_write(16'h7FFD, 8'hC2, 1);
		expect_access(rand_addr(2'd3), 1'b1, 8'h2A, 1'b1);
		random_sweep(10);
		apply_reset(MACH_128);
		io_write(16'h7FFD, 8'hC1, 1);
		io_write(`ZX_PORT_DFFD, 8'h07, 1);
		expect_access(rand_addr(2'd3), 1'b0, 8'h01, 1'b0);

		// +3 ROM select and all-RAM layouts
		apply_reset(MACH_PLUS3);
		io_write(16'h7FFD, 8'h10, 1);
		expect_access(rand_addr(2'd0), 1'b0, 8'h85, 1'b0);
		io_write(16'h1FFD, 8'h04, 1);
		io_write(16'h3FFD, 8'h00, 1);
		expect_access(rand_addr(2'd0), 1'b1, 8'h87, 1'b0);
		random_sweep(10);
		for (int c = 0; c < 4; c++) begin
			io_write(16'h1FFD, {5'd0, c[1:0], 1'b1}, 1);
			expect_access(rand_addr(2'd0), 1'b1, {5'd0, all_ram_bank(c[1:0], 2'd0)}, 1'b1);
			expect_access(rand_addr(2'd1), 1'b1, {5'd0, all_ram_bank(c[1:0], 2'd1)}, 1'b1);
			expect_access(rand_addr(2'd2), 1'b0, {5'd0, all_ram_bank(c[1:0], 2'd2)}, 1'b0);
			expect_access(rand_addr(2'd3), 1'b1, {5'd0, all_ram_bank(c[1:0], 2'd3)}, 1'b1);
			random_sweep(6);
		end
		io_write(16'h1FFD, 8'h00, 1);
		expect_access(rand_addr(2'd0), 1'b0, 8'h85, 1'b0);

		// TR-DOS entry and exit
		apply_reset(MACH_48);
		fetch(16'h3D2F);
		expect_access(rand_addr(2'd0), 1'b0, 8'h81, 1'b0);
		fetch(16'h1234);
		expect_access(rand_addr(2'd0), 1'b0, 8'h81, 1'b0);
		fetch(16'h8000);
		expect_access(rand_addr(2'd0), 1'b0, 8'h83, 1'b0);
		io_write(16'h7FFD, 8'h07, 1);
		expect_access(rand_addr(2'd3), 1'b0, 8'h00, 1'b0);
		random_sweep(20);
		apply_reset(MACH_128);
		fetch(16'h3D00);
		expect_access(rand_addr(2'd0), 1'b0, 8'h82, 1'b0);
		io_write(16'h7FFD, 8'h10, 1);
		fetch(16'h3DFF);
		expect_access(rand_addr(2'd0), 1'b0, 8'h81, 1'b0);
		fetch(16'hC000);
		expect_access(rand_addr(2'd0), 1'b0, 8'h83, 1'b0);
		random_sweep(20);

		repeat (2) next_drive();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

//--- flist.f
+incdir+.
zx_mem_pkg.sv
zx_page_regs.sv
zx_rom_pager.sv
zx_addr_map.sv
zx_mem_top.sv
tb_zx_mem.sv

//--- run.sh
#!/bin/sh
# Build and run the paging unit testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_zx_mem -o tb_zx_mem

out=$(./obj_dir/tb_zx_mem)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1
